// File: hsi_wrapper_top.f
source/hsi_bus_pkg.sv
source/hsi_core_pkg.sv
source/obi_resp_fsm.sv
source/cfg_regs.sv
source/cmd_status.sv
source/hsi_wrapper_top.sv
tests/hsi_wrapper_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, from the project root

LOG=sim.log

verilator --binary --timing --top-module hsi_wrapper_tb -f hsi_wrapper_top.f -o hsi_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/hsi_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: source/cfg_regs.sv
`default_nettype none

module cfg_regs (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire hsi_bus_pkg::reg_wr_t    reg_wr_i,
    output hsi_core_pkg::core_cfg_t      cfg_o
);
    import hsi_core_pkg::*;

    localparam int NB_BYTES = NUM_BANDS_WIDTH / 8;

    core_cfg_t cfg_q;
    logic      op_wr;  // Op code strobe
    logic      nb_wr;  // Band count strobe

    // Byte-wise merge of new data into the old value
    function automatic logic [NUM_BANDS_WIDTH-1:0] merge_bytes(
        input logic [NUM_BANDS_WIDTH-1:0] old_val,
        input logic [NUM_BANDS_WIDTH-1:0] new_val,
        input logic [NB_BYTES-1:0]        be
    );
        logic [NUM_BANDS_WIDTH-1:0] res;
        res = old_val;
        for (int b = 0; b < NB_BYTES; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Op code lives in byte 0 only
    assign op_wr = reg_wr_i.valid && (reg_wr_i.sel == hsi_bus_pkg::OPCODE) && reg_wr_i.be[0];
    assign nb_wr = reg_wr_i.valid && (reg_wr_i.sel == hsi_bus_pkg::NUM_BANDS);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '0;  // Both read zero after reset
        end else begin
            if (op_wr) begin
                cfg_q.op_code <= reg_wr_i.wdata[OP_CODE_WIDTH-1:0];
            end
            if (nb_wr) begin
                cfg_q.num_bands <= merge_bytes(cfg_q.num_bands, reg_wr_i.wdata,
                                               reg_wr_i.be);
            end
        end
    end

    assign cfg_o = cfg_q;  // Straight to core and readback

endmodule

`default_nettype wire

// File: source/cmd_status.sv
`default_nettype none

module cmd_status (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire hsi_bus_pkg::reg_wr_t    reg_wr_i,
    input  wire hsi_core_pkg::core_evt_t evt_i,
    output logic                         start_o,
    output hsi_core_pkg::core_stat_t     stat_o
);
    import hsi_bus_pkg::*;
    import hsi_core_pkg::*;

    logic                     cmd_wr;
    logic [CMD_CLEAR_ERROR:0] cmd;       // Command bits after byte enable
    logic                     start_ok;  // START accepted, core idle
    logic                     evt_err;   // Core reports a fault
    logic                     start_q;
    core_stat_t               stat_q;

    // ================================================
    // Command decode
    // ================================================
    assign cmd_wr   = reg_wr_i.valid && (reg_wr_i.sel == COMMAND);
    assign cmd      = (cmd_wr && reg_wr_i.be[0]) ? reg_wr_i.wdata[CMD_CLEAR_ERROR:0] : '0;
    assign start_ok = cmd[CMD_START] && !stat_q.busy;  // Ignored while busy
    assign evt_err  = (evt_i.error_code != '0);

    // ================================================
    // Flags and start pulse
    // ================================================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_q <= 1'b0;
            stat_q  <= '0;
        end else begin
            start_q <= start_ok;  // Single cycle, lines up with rvalid

            // Commands first
            if (cmd[CMD_CLEAR_DONE]) begin
                stat_q.done <= 1'b0;
            end
            if (cmd[CMD_CLEAR_ERROR]) begin
                stat_q.error_code <= '0;
            end
            if (start_ok) begin
                stat_q.done <= 1'b0;  // New run drops old done
                stat_q.busy <= 1'b1;
            end

            // Core events last, so they win over clears
            if (evt_err) begin
                stat_q.error_code <= evt_i.error_code;
                stat_q.busy       <= 1'b0;
            end
            if (evt_i.pixel_done) begin
                stat_q.done <= 1'b1;
                stat_q.busy <= 1'b0;
            end
        end
    end

    assign start_o = start_q;
    assign stat_o  = stat_q;

endmodule

`default_nettype wire

// File: source/hsi_bus_pkg.sv
`default_nettype none

package hsi_bus_pkg;

    // ================================================
    // Bus geometry
    // ================================================
    localparam int BUS_WIDTH = 32;            // OBI data width
    localparam int BE_WIDTH  = BUS_WIDTH / 8; // One enable per byte
    localparam int ADDR_BITS = 6;             // Only low bits decoded

    // Register map, byte addresses
    localparam logic [ADDR_BITS-1:0] ADDR_OPCODE      = 6'h00; // RW
    localparam logic [ADDR_BITS-1:0] ADDR_NUM_BANDS   = 6'h04; // RW
    localparam logic [ADDR_BITS-1:0] ADDR_COMMAND     = 6'h08; // WO, reads zero
    localparam logic [ADDR_BITS-1:0] ADDR_STATUS      = 6'h0C; // RO
    localparam logic [ADDR_BITS-1:0] ADDR_FIFO_STATUS = 6'h10; // RO

    // ================================================
    // Bus transaction types
    // ================================================
    typedef struct packed {
        logic                 req;   // Master request
        logic                 we;    // 1 write, 0 read
        logic [BE_WIDTH-1:0]  be;    // Byte enables
        logic [31:0]          addr;  // Full byte address
        logic [BUS_WIDTH-1:0] wdata; // Write data
    } obi_req_t;

    typedef struct packed {
        logic                 gnt;    // Request accepted
        logic                 rvalid; // Response valid, one cycle
        logic                 err;    // Bad address
        logic [BUS_WIDTH-1:0] rdata;  // Read data
    } obi_rsp_t;

    // Decoded target of an access
    typedef enum logic [2:0] {
        OPCODE      = 3'd0,
        NUM_BANDS   = 3'd1,
        COMMAND     = 3'd2,
        STATUS      = 3'd3,
        FIFO_STATUS = 3'd4
    } reg_sel_e;

    // Write committed at the grant edge
    typedef struct packed {
        logic                 valid; // Granted write to a mapped address
        reg_sel_e             sel;   // Target register
        logic [BE_WIDTH-1:0]  be;
        logic [BUS_WIDTH-1:0] wdata;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: source/hsi_core_pkg.sv
`default_nettype none

package hsi_core_pkg;

    // ================================================
    // Core-side widths and command bits
    // ================================================
    localparam int OP_CODE_WIDTH   = 4;
    localparam int NUM_BANDS_WIDTH = 32;
    localparam int ERR_WIDTH       = 4;

    // Bit positions in the command word
    localparam int CMD_START       = 0; // Kick the core
    localparam int CMD_CLEAR_DONE  = 1;
    localparam int CMD_CLEAR_ERROR = 2;

    // ================================================
    // Core-facing structs
    // ================================================
    typedef struct packed {
        logic [OP_CODE_WIDTH-1:0]   op_code;   // Operation select
        logic [NUM_BANDS_WIDTH-1:0] num_bands; // Spectral bands per pixel
    } core_cfg_t;

    typedef struct packed {
        logic                 pixel_done; // One pixel finished
        logic [ERR_WIDTH-1:0] error_code; // Non-zero means fault
    } core_evt_t;

    typedef struct packed {
        logic                 done;
        logic [ERR_WIDTH-1:0] error_code; // Sticky until cleared
        logic                 busy;
    } core_stat_t;

    // Declared MSB first, so in1_full lands at bit 0
    typedef struct packed {
        logic in2_empty; // Bit 5
        logic in1_empty;
        logic out_empty;
        logic out_full;
        logic in2_full;
        logic in1_full;  // Bit 0
    } fifo_stat_t;

    // ================================================
    // Read word views
    // ================================================
    typedef struct packed {
        logic [hsi_bus_pkg::BUS_WIDTH-10:0] rsvd_hi;    // 31:9
        logic                               busy;       // 8
        logic [7-ERR_WIDTH-1:0]             rsvd_lo;    // 7:5
        logic [ERR_WIDTH-1:0]               error_code; // 4:1
        logic                               done;       // 0
    } status_word_t;

    typedef struct packed {
        logic [hsi_bus_pkg::BUS_WIDTH-$bits(fifo_stat_t)-1:0] rsvd;
        fifo_stat_t                                           flags; // 5:0
    } fifo_word_t;

    // Same 32 bits, decoded per register
    typedef union packed {
        logic [hsi_bus_pkg::BUS_WIDTH-1:0] raw;
        status_word_t                      status;
        fifo_word_t                        fifo;
    } rd_word_u;

endpackage

`default_nettype wire

// File: source/hsi_wrapper_top.sv
`default_nettype none

module hsi_wrapper_top (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,

    // OBI slave port
    input  wire hsi_bus_pkg::obi_req_t    bus_req_i,
    output hsi_bus_pkg::obi_rsp_t         bus_rsp_o,

    // Towards the vector core
    output hsi_core_pkg::core_cfg_t       cfg_o,
    output logic                          start_o,

    // From the vector core and its FIFOs
    input  wire hsi_core_pkg::core_evt_t  evt_i,
    input  wire hsi_core_pkg::fifo_stat_t fifo_i
);
    import hsi_bus_pkg::*;
    import hsi_core_pkg::*;

    reg_wr_t    reg_wr;  // Shared write port
    core_stat_t stat;    // Flags for readback

    // ================================================
    // Bus side
    // ================================================
    obi_resp_fsm u_obi_resp_fsm (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .bus_req_i (bus_req_i),
        .bus_rsp_o (bus_rsp_o),
        .reg_wr_o  (reg_wr),
        .cfg_i     (cfg_o),    // Readback of live config
        .stat_i    (stat),
        .fifo_i    (fifo_i)
    );

    // ================================================
    // Register side
    // ================================================
    cfg_regs u_cfg_regs (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .reg_wr_i (reg_wr),
        .cfg_o    (cfg_o)
    );

    cmd_status u_cmd_status (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .reg_wr_i (reg_wr),
        .evt_i    (evt_i),
        .start_o  (start_o),
        .stat_o   (stat)
    );

endmodule

`default_nettype wire

// File: source/obi_resp_fsm.sv
`default_nettype none

module obi_resp_fsm (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire hsi_bus_pkg::obi_req_t    bus_req_i,
    output hsi_bus_pkg::obi_rsp_t         bus_rsp_o,
    output hsi_bus_pkg::reg_wr_t          reg_wr_o,
    input  wire hsi_core_pkg::core_cfg_t  cfg_i,
    input  wire hsi_core_pkg::core_stat_t stat_i,
    input  wire hsi_core_pkg::fifo_stat_t fifo_i
);
    import hsi_bus_pkg::*;
    import hsi_core_pkg::*;

    typedef enum logic {
        S_IDLE, // Waiting for req
        S_RESP  // rvalid cycle, no grant
    } state_e;

    state_e               state_q, state_d;
    logic [ADDR_BITS-1:0] addr_low;
    logic [ADDR_BITS-1:0] addr_q;   // Latched at grant
    logic                 we_q;
    logic                 err_q;
    logic                 addr_valid;
    logic                 grant;
    reg_sel_e             sel_dec;
    rd_word_u             rd_word;

    // ================================================
    // Address decode
    // ================================================
    assign addr_low = bus_req_i.addr[ADDR_BITS-1:0];

    always_comb begin
        addr_valid = 1'b1;
        unique case (addr_low)
            ADDR_OPCODE:      sel_dec = OPCODE;
            ADDR_NUM_BANDS:   sel_dec = NUM_BANDS;
            ADDR_COMMAND:     sel_dec = COMMAND;
            ADDR_STATUS:      sel_dec = STATUS;
            ADDR_FIFO_STATUS: sel_dec = FIFO_STATUS;
            default: begin
                sel_dec    = OPCODE;  // Don't care, valid is low
                addr_valid = 1'b0;
            end
        endcase
    end

    // ================================================
    // Grant / response machine
    // ================================================
    assign grant = (state_q == S_IDLE) && bus_req_i.req;

    // Write goes out in the grant cycle, committed at that edge
    assign reg_wr_o.valid = grant && bus_req_i.we && addr_valid;
    assign reg_wr_o.sel   = sel_dec;
    assign reg_wr_o.be    = bus_req_i.be;
    assign reg_wr_o.wdata = bus_req_i.wdata;

    always_comb begin
        state_d   = state_q;
        bus_rsp_o = '0;
        unique case (state_q)
            S_IDLE: begin
                bus_rsp_o.gnt = bus_req_i.req; // Same-cycle grant
                if (bus_req_i.req) begin
                    state_d = S_RESP;
                end
            end
            S_RESP: begin
                bus_rsp_o.rvalid = 1'b1;
                bus_rsp_o.err    = err_q;
                bus_rsp_o.rdata  = rd_word.raw; // Zero for writes
                state_d          = S_IDLE;      // Always back, one beat
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= S_IDLE;
            addr_q  <= '0;
            we_q    <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (grant) begin
                addr_q <= addr_low;
                we_q   <= bus_req_i.we;
                err_q  <= ~addr_valid;
            end
        end
    end

    // ================================================
    // Read data, sampled live in the response cycle
    // ================================================
    always_comb begin
        rd_word = '0;
        if (!we_q) begin
            unique case (addr_q)
                ADDR_OPCODE:    rd_word.raw = BUS_WIDTH'(cfg_i.op_code);
                ADDR_NUM_BANDS: rd_word.raw = cfg_i.num_bands;
                ADDR_STATUS: begin
                    rd_word.status.done       = stat_i.done;
                    rd_word.status.error_code = stat_i.error_code;
                    rd_word.status.busy       = stat_i.busy;
                end
                ADDR_FIFO_STATUS: rd_word.fifo.flags = fifo_i;
                default: ;  // COMMAND and bad addresses read zero
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tests/hsi_wrapper_tb.sv
`default_nettype none

module hsi_wrapper_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import hsi_bus_pkg::*;
    import hsi_core_pkg::*;

    localparam int N_TRANS  = 130;               // Upper bound on bus accesses
    localparam int WD_LIMIT = N_TRANS * 4 + 100; // Watchdog budget in cycles

    logic       clk;
    logic       rst_n;
    obi_req_t   bus_req;
    obi_rsp_t   bus_rsp;
    core_cfg_t  cfg;
    logic       start;
    core_evt_t  evt;
    fifo_stat_t fifo;

    // Register model, updated at grant and on core events
    logic [OP_CODE_WIDTH-1:0]   m_op;
    logic [NUM_BANDS_WIDTH-1:0] m_nb;
    logic                       m_done;
    logic [ERR_WIDTH-1:0]       m_err;
    logic                       m_busy;

    obi_rsp_t    exp_q[$];   // Responses queued at grant
    obi_rsp_t    exp_rsp;
    obi_rsp_t    pend;
    logic        gnt_seen;   // Grant expected in the last cycle
    logic        start_exp;
    logic        started;
    logic [15:0] lfsr;
    int          rsp_errs   = 0;
    int          cfg_errs   = 0;
    int          start_errs = 0;
    int          drv_errs   = 0;

    hsi_wrapper_top dut0 (
        .clk_i     (clk),
        .rst_ni    (rst_n),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .cfg_o     (cfg),
        .start_o   (start),
        .evt_i     (evt),
        .fifo_i    (fifo)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        repeat (WD_LIMIT) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test did not finish", WD_LIMIT);
        $display("Errors found");
        $finish;
    end

    // ================================================
    // Stimulus helpers and reference model
    // ================================================
    // Taps 16,14,13,11; one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] cmd_word(input int bit_pos);
        logic [31:0] w;
        w          = '0;
        w[bit_pos] = 1'b1;
        return w;
    endfunction

    function automatic logic addr_ok(input logic [31:0] a);
        case (a[ADDR_BITS-1:0])
            ADDR_OPCODE, ADDR_NUM_BANDS, ADDR_COMMAND,
            ADDR_STATUS, ADDR_FIFO_STATUS: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Expected read word from the model
    function automatic logic [31:0] ref_read(input logic [31:0] a);
        logic [31:0] w;
        w = '0;
        case (a[ADDR_BITS-1:0])
            ADDR_OPCODE:    w[OP_CODE_WIDTH-1:0] = m_op;
            ADDR_NUM_BANDS: w = m_nb;
            ADDR_STATUS: begin
                w[0]   = m_done;
                w[4:1] = m_err;
                w[8]   = m_busy;
            end
            ADDR_FIFO_STATUS: w[5:0] = {fifo.in2_empty, fifo.in1_empty, fifo.out_empty,
                                        fifo.out_full, fifo.in2_full, fifo.in1_full};
            default: w = '0;   // COMMAND and holes
        endcase
        return w;
    endfunction

    task automatic model_write(input obi_req_t r, output logic start_hit);
        start_hit = 1'b0;
        case (r.addr[ADDR_BITS-1:0])
            ADDR_OPCODE: if (r.be[0]) m_op = r.wdata[OP_CODE_WIDTH-1:0];
            ADDR_NUM_BANDS: begin
                for (int b = 0; b < BE_WIDTH; b++) begin
                    if (r.be[b]) m_nb[8*b +: 8] = r.wdata[8*b +: 8];
                end
            end
            ADDR_COMMAND: if (r.be[0]) begin
                if (r.wdata[CMD_CLEAR_DONE]) m_done = 1'b0;
                if (r.wdata[CMD_CLEAR_ERROR]) m_err = '0;
                if (r.wdata[CMD_START] && !m_busy) begin
                    m_done    = 1'b0;   // New run drops done
                    m_busy    = 1'b1;
                    start_hit = 1'b1;
                end
            end
            default: ;   // Read-only or unmapped
        endcase
    endtask

    // ================================================
    // Compare tasks
    // ================================================
    task automatic check_rsp(input obi_rsp_t got, input obi_rsp_t exp);
        if (got !== exp) begin
            rsp_errs++;
            $display("CHECK FAILED at %0t: gnt/rvalid/err/rdata %b %b %b %h, expected %b %b %b %h",
                     $time, got.gnt, got.rvalid, got.err, got.rdata,
                     exp.gnt, exp.rvalid, exp.err, exp.rdata);
        end
    endtask

    task automatic check_cfg(input core_cfg_t got, input core_cfg_t exp);
        if (got !== exp) begin
            cfg_errs++;
            $display("CHECK FAILED at %0t: cfg_o op %h bands %h, expected op %h bands %h",
                     $time, got.op_code, got.num_bands, exp.op_code, exp.num_bands);
        end
    endtask

    task automatic check_start(input logic got, input logic exp);
        if (got !== exp) begin
            start_errs++;
            $display("CHECK FAILED at %0t: start_o %b, expected %b", $time, got, exp);
        end
    endtask

    // Whole response compared every cycle, stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            m_op      = '0;
            m_nb      = '0;
            m_done    = 1'b0;
            m_err     = '0;
            m_busy    = 1'b0;
            gnt_seen  = 1'b0;
            start_exp = 1'b0;
        end else begin
            exp_rsp        = '0;
            exp_rsp.rvalid = gnt_seen;                   // One cycle after grant
            exp_rsp.gnt    = bus_req.req && !gnt_seen;   // No grant while responding
            if (gnt_seen && exp_q.size() > 0) begin
                pend          = exp_q.pop_front();
                exp_rsp.err   = pend.err;
                exp_rsp.rdata = pend.rdata;
            end
            check_rsp(bus_rsp, exp_rsp);
            check_cfg(cfg, core_cfg_t'({m_op, m_nb}));
            check_start(start, start_exp);
            started = 1'b0;
            if (exp_rsp.gnt && bus_req.we) model_write(bus_req, started);
            start_exp = started;
            // Core events last, they beat clears
            if (evt.error_code != '0) begin
                m_err  = evt.error_code;
                m_busy = 1'b0;
            end
            if (evt.pixel_done) begin
                m_done = 1'b1;
                m_busy = 1'b0;
            end
            if (exp_rsp.gnt) begin
                pend       = '0;
                pend.err   = !addr_ok(bus_req.addr);
                pend.rdata = bus_req.we ? '0 : ref_read(bus_req.addr);
                exp_q.push_back(pend);
            end
            gnt_seen = exp_rsp.gnt;
        end
    end

    // ================================================
    // Bus driver, called 10 ns after a rising edge
    // ================================================
    task automatic bus_access(input logic we, input logic [ADDR_BITS-1:0] addr,
                              input logic [BE_WIDTH-1:0] be, input logic [31:0] wdata);
        int waited;
        waited        = 0;
        bus_req.req   = 1'b1;
        bus_req.we    = we;
        bus_req.be    = be;
        bus_req.addr  = {{(32-ADDR_BITS){1'b0}}, addr};
        bus_req.wdata = wdata;
        @(negedge clk);
        while (!bus_rsp.gnt && waited < 2) begin
            waited++;
            @(negedge clk);
        end
        if (!bus_rsp.gnt) begin
            drv_errs++;
            $display("No grant within two cycles for address %h at %0t", addr, $time);
        end
        @(posedge clk);
        #10;   // Req stays up, next call may follow back to back
    endtask

    // Drops req and waits for the DUT to answer the last grant
    task automatic bus_idle();
        int n;
        n           = 0;
        bus_req.req = 1'b0;
        @(negedge clk);
        while (!bus_rsp.rvalid && n < 4) begin
            n++;
            @(negedge clk);
        end
        if (!bus_rsp.rvalid) begin
            drv_errs++;
            $display("No response to the last grant before %0t", $time);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic pulse_event(input logic pd, input logic [ERR_WIDTH-1:0] code);
        evt.pixel_done = pd;
        evt.error_code = code;
        @(posedge clk);
        #10;
        evt = '0;
    endtask

    // ================================================
    // Test sequence
    // ================================================
    initial begin
        logic [31:0]          r;
        logic [31:0]          wd;
        logic [BE_WIDTH-1:0]  be;
        logic [ADDR_BITS-1:0] bad_addr [5];
        int                   total;
        lfsr     = 16'd52799;
        bad_addr = '{6'h14, 6'h20, 6'h3C, 6'h01, 6'h0E};
        rst_n    = 1'b0;
        bus_req  = '0;
        evt      = '0;
        fifo     = '0;
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;

        // Everything zero after reset, held req
        for (int a = 0; a <= 16; a += 4) bus_access(1'b0, 6'(a), 4'hF, '0);
        bus_idle();

        // Random config writes with random byte enables
        for (int i = 0; i < 12; i++) begin
            wd = rand_bits(32);
            r  = rand_bits(4);
            be = r[BE_WIDTH-1:0];
            bus_access(1'b1, ADDR_OPCODE, be, wd);
            wd = rand_bits(32);
            r  = rand_bits(4);
            be = r[BE_WIDTH-1:0];
            bus_access(1'b1, ADDR_NUM_BANDS, be, wd);
            bus_access(1'b0, ADDR_OPCODE, 4'hF, '0);
            bus_access(1'b0, ADDR_NUM_BANDS, 4'hF, '0);
        end
        bus_idle();

        // Holes give err, read-only writes and masked command are dropped
        for (int i = 0; i < 5; i++) begin
            bus_access(1'b1, bad_addr[i], 4'hF, rand_bits(32));
            bus_access(1'b0, bad_addr[i], 4'hF, '0);
        end
        bus_access(1'b1, ADDR_STATUS, 4'hF, 32'hFFFF_FFFF);
        bus_access(1'b1, ADDR_FIFO_STATUS, 4'hF, 32'hFFFF_FFFF);
        bus_access(1'b1, ADDR_COMMAND, 4'hE, 32'h7);
        bus_access(1'b0, ADDR_OPCODE, 4'hF, '0);
        bus_access(1'b0, ADDR_NUM_BANDS, 4'hF, '0);
        bus_access(1'b0, ADDR_COMMAND, 4'hF, '0);
        bus_access(1'b0, ADDR_STATUS, 4'hF, '0);

        // Start pulse, then a second start while busy
        bus_access(1'b1, ADDR_COMMAND, 4'h1, cmd_word(CMD_START));
        bus_access(1'b0, ADDR_STATUS, 4'hF, '0);
        bus_access(1'b1, ADDR_COMMAND, 4'h1, cmd_word(CMD_START));
        bus_access(1'b0, ADDR_STATUS, 4'hF, '0);
        bus_idle();

        // Core events and clears
        pulse_event(1'b1, '0);
        bus_access(1'b0, ADDR_STATUS, 4'hF, '0);
        evt.pixel_done = 1'b1;   // Same cycle as a clear
        bus_access(1'b1, ADDR_COMMAND, 4'h1, cmd_word(CMD_CLEAR_DONE));
        evt = '0;
        bus_access(1'b0, ADDR_STATUS, 4'hF, '0);
        bus_access(1'b1, ADDR_COMMAND, 4'h1, cmd_word(CMD_CLEAR_DONE));
        bus_access(1'b0, ADDR_STATUS, 4'hF, '0);
        bus_access(1'b1, ADDR_COMMAND, 4'h1, cmd_word(CMD_START));
        bus_idle();
        pulse_event(1'b0, 4'hA);
        bus_access(1'b0, ADDR_STATUS, 4'hF, '0);
        bus_access(1'b1, ADDR_COMMAND, 4'h1, cmd_word(CMD_CLEAR_ERROR));
        bus_access(1'b0, ADDR_STATUS, 4'hF, '0);
        bus_idle();

        // FIFO flags, held until the read has answered
        for (int i = 0; i < 8; i++) begin
            r    = rand_bits(6);
            fifo = r[5:0];
            bus_access(1'b0, ADDR_FIFO_STATUS, 4'hF, '0);
            bus_idle();
        end

        total = rsp_errs + cfg_errs + start_errs + drv_errs;
        $display("Error counts: response %0d, config %0d, start %0d, driver %0d",
                 rsp_errs, cfg_errs, start_errs, drv_errs);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
